// File: isa_pkg.sv
package isa_pkg;

  // register view: ra = destination (or store source), rb and rc = sources
  typedef enum logic [7:0] {
    OP_HALT  = 8'h00,  // also taken by any undefined opcode
    OP_ADD   = 8'h01,  // ra = rb + rc
    OP_SUB   = 8'h02,  // ra = rb - rc
    OP_AND   = 8'h03,
    OP_OR    = 8'h04,
    OP_XOR   = 8'h05,
    OP_SHL   = 8'h06,  // ra = rb << rc[4:0]
    OP_SHR   = 8'h07,  // logical
    OP_ADDI  = 8'h08,  // ra = rb + sext(imm)
    OP_LDI   = 8'h10,  // ra = word following the instruction
    OP_LD    = 8'h11,  // ra = mem[rb + sext(imm)]
    OP_ST    = 8'h12,  // mem[rb + sext(imm)] = ra
    OP_STB   = 8'h13,  // byte lane picked by the address low bits
    OP_MULS  = 8'h20,  // ra = low word of rb * rc, signed
    OP_MULU  = 8'h21,
    OP_MULSH = 8'h22,  // high word
    OP_MULUH = 8'h23,
    OP_NEG   = 8'h30,  // ra = -rb
    OP_COM   = 8'h31,  // ra = ~rb
    OP_MOV   = 8'h32,  // ra = rb
    OP_BR    = 8'h40,  // pc = pc + 4 + offset * 4 when cond holds
    OP_JMP   = 8'h41   // pc = rb
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SHL = 3'd5,
    ALU_SHR = 3'd6
  } alu_func_e;

  typedef enum logic [2:0] {
    INT_MULS = 3'd0,
    INT_MULU = 3'd1
  } int_func_e;

  // flags are held as {carry, negative, overflow, zero}
  typedef enum logic [3:0] {
    COND_AL = 4'd0,
    COND_EQ = 4'd1,
    COND_NE = 4'd2,
    COND_LT = 4'd3,  // signed, n ^ v
    COND_GE = 4'd4,
    COND_CS = 4'd5   // carry set, borrow after a subtract
  } cond_e;

  // low 11 bits are either the immediate or hold rc in [4:0]
  typedef struct packed {
    logic [5:0] unused;
    logic [4:0] rc;
  } rc_field_t;

  typedef union packed {
    logic signed [10:0] imm;
    rc_field_t          regs;
  } operand_t;

  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [2:0] unused;
    operand_t   op;
  } reg_view_t;

  typedef struct packed {
    opcode_e            opcode;
    cond_e              cond;
    logic [3:0]         unused;
    logic signed [15:0] offset;  // in words
  } bra_view_t;

  typedef union packed {
    reg_view_t r;
    bra_view_t b;
  } instr_t;

endpackage

// File: ctrl_pkg.sv
package ctrl_pkg;

  typedef enum logic [1:0] {
    PC_HOLD   = 2'd0,
    PC_INC    = 2'd1,
    PC_MAR    = 2'd2,
    PC_ALUVAL = 2'd3
  } pcsel_e;

  typedef enum logic [1:0] {
    MAR_HOLD = 2'd0,
    MAR_ALU  = 2'd1,  // straight from the ALU output
    MAR_REG  = 2'd2
  } marsel_e;

  typedef enum logic [2:0] {
    MDR_HOLD  = 3'd0,
    MDR_READ  = 3'd1,
    MDR_REG   = 3'd2,
    MDR_BYTE  = 3'd3,  // low byte copied to every lane
    MDR_INTLO = 3'd4,
    MDR_INTHI = 3'd5
  } mdrsel_e;

  typedef enum logic [2:0] {
    REG_ALUVAL = 3'd0,
    REG_MDR    = 3'd1,
    REG_NEG    = 3'd2,
    REG_COM    = 3'd3,
    REG_MOV    = 3'd4
  } regsel_e;

  typedef enum logic [1:0] {
    ALU1_REG = 2'd0,
    ALU1_PC  = 2'd1
  } alu1sel_e;

  typedef enum logic [2:0] {
    ALU2_REG = 3'd0,
    ALU2_IMM = 3'd1,
    ALU2_BRA = 3'd2
  } alu2sel_e;

  typedef enum logic [1:0] {
    INT2_REG = 2'd0,
    INT2_MDR = 2'd1
  } int2sel_e;

  typedef enum logic [4:0] {
    S_RESET, S_FETCH, S_DECODE,
    S_ARITH, S_ARITH_WB, S_UNARY,
    S_LDI, S_LDI_WB,
    S_MEM_ADDR, S_LOAD, S_LOAD_WB, S_STORE,
    S_MUL, S_MUL_MDR, S_MUL_WB,
    S_BRANCH, S_BRANCH_PC, S_JUMP, S_JUMP_PC,
    S_HALT
  } state_e;

endpackage

// File: alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [31:0]          in1,
  input  logic [31:0]          in2,
  input  isa_pkg::alu_func_e   func,
  output logic [31:0]          out,
  output logic                 c_out,
  output logic                 n_out,
  output logic                 v_out,
  output logic                 z_out
);
  import isa_pkg::*;

  logic [32:0] sum;
  logic [32:0] diff;

  assign sum  = {1'b0, in1} + {1'b0, in2};
  assign diff = {1'b0, in1} - {1'b0, in2};  // bit 32 is the borrow

  always_comb begin
    c_out = 1'b0;
    v_out = 1'b0;
    case (func)
      ALU_ADD: begin
        out   = sum[31:0];
        c_out = sum[32];
        v_out = (in1[31] == in2[31]) && (sum[31] != in1[31]);
      end
      ALU_SUB: begin
        out   = diff[31:0];
        c_out = diff[32];
        v_out = (in1[31] != in2[31]) && (diff[31] != in1[31]);
      end
      ALU_AND: out = in1 & in2;
      ALU_OR:  out = in1 | in2;
      ALU_XOR: out = in1 ^ in2;
      ALU_SHL: out = in1 << in2[4:0];
      ALU_SHR: out = in1 >> in2[4:0];
      default: out = 32'h0;
    endcase
  end

  assign n_out = out[31];
  assign z_out = (out == 32'h0);

endmodule

// File: intcalc.sv
`timescale 1ns/1ps

module intcalc (
  input  logic               clk,
  input  isa_pkg::int_func_e func,
  input  logic [31:0]        in1,
  input  logic [31:0]        in2,
  output logic [63:0]        out
);
  import isa_pkg::*;

  logic [63:0] op1;
  logic [63:0] op2;
  logic [63:0] product;
  logic        is_signed;

  assign is_signed = (func == INT_MULS);

  // widen to 64 bits, the low 64 bits of the product are then exact for both cases
  assign op1 = is_signed ? {{32{in1[31]}}, in1} : {32'h0, in1};
  assign op2 = is_signed ? {{32{in2[31]}}, in2} : {32'h0, in2};

  assign product = op1 * op2;

  always_ff @(posedge clk) begin
    out <= product;  // valid one cycle after the operands
  end

endmodule

// File: registerfile.sv
`timescale 1ns/1ps

module registerfile (
  input  logic        clk,
  input  logic        reset_n,
  input  logic [4:0]  read1,
  input  logic [4:0]  read2,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data,
  input  logic        write_en,
  output logic [31:0] data1,
  output logic [31:0] data2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (write_en && write_addr != 5'd0) begin
      regs[write_addr] <= write_data;
    end
  end

  // r0 is hardwired to zero
  assign data1 = (read1 == 5'd0) ? 32'h0 : regs[read1];
  assign data2 = (read2 == 5'd0) ? 32'h0 : regs[read2];

endmodule

// File: control.sv
`timescale 1ns/1ps

module control (
  input  logic               clk,
  input  logic               reset_n,
  input  isa_pkg::instr_t    ir,
  input  logic [3:0]         ccr,
  input  logic [1:0]         mar_low,
  input  logic               waitrequest,
  output ctrl_pkg::pcsel_e   pcsel,
  output ctrl_pkg::marsel_e  marsel,
  output ctrl_pkg::mdrsel_e  mdrsel,
  output ctrl_pkg::regsel_e  regsel,
  output ctrl_pkg::alu1sel_e alu1sel,
  output ctrl_pkg::alu2sel_e alu2sel,
  output ctrl_pkg::int2sel_e int2sel,
  output logic [4:0]         reg_read_addr1,
  output logic [4:0]         reg_read_addr2,
  output logic [4:0]         reg_write_addr,
  output logic               reg_write,
  output logic               ir_write,
  output logic               ccr_write,
  output isa_pkg::alu_func_e alu_func,
  output isa_pkg::int_func_e int_func,
  output logic               addrsel,
  output logic               read,
  output logic               write,
  output logic [3:0]         byteenable
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  state_e     state;
  state_e     next_state;
  opcode_e    opcode;
  logic [4:0] ra;
  logic [4:0] rb;
  logic [4:0] rc;
  logic       cond_true;
  logic       is_byte;
  logic       mul_signed;
  logic       mul_high;
  logic [3:0] lane_be;

  assign opcode     = ir.r.opcode;
  assign ra         = ir.r.ra;
  assign rb         = ir.r.rb;
  assign rc         = ir.r.op.regs.rc;
  assign is_byte    = (opcode == OP_STB);
  assign mul_signed = (opcode == OP_MULS) || (opcode == OP_MULSH);
  assign mul_high   = (opcode == OP_MULSH) || (opcode == OP_MULUH);
  assign lane_be    = 4'b0001 << mar_low;  // little endian lanes

  always_comb begin
    case (ir.b.cond)
      COND_AL: cond_true = 1'b1;
      COND_EQ: cond_true = ccr[0];
      COND_NE: cond_true = !ccr[0];
      COND_LT: cond_true = ccr[2] ^ ccr[1];
      COND_GE: cond_true = !(ccr[2] ^ ccr[1]);
      COND_CS: cond_true = ccr[3];
      default: cond_true = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= S_RESET;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state     = state;
    pcsel          = PC_HOLD;
    marsel         = MAR_HOLD;
    mdrsel         = MDR_HOLD;
    regsel         = REG_ALUVAL;
    alu1sel        = ALU1_REG;
    alu2sel        = ALU2_REG;
    int2sel        = INT2_REG;
    reg_read_addr1 = rb;
    reg_read_addr2 = rc;
    reg_write_addr = ra;
    reg_write      = 1'b0;
    ir_write       = 1'b0;
    ccr_write      = 1'b0;
    alu_func       = ALU_ADD;
    int_func       = INT_MULU;
    addrsel        = 1'b0;
    read           = 1'b0;
    write          = 1'b0;
    byteenable     = 4'b1111;
    case (state)
      S_RESET: next_state = S_FETCH;  // one idle cycle keeps the bus quiet out of reset
      S_FETCH: begin
        read = 1'b1;
        if (!waitrequest) begin
          ir_write   = 1'b1;
          pcsel      = PC_INC;
          next_state = S_DECODE;
        end
      end
      S_DECODE: begin
        case (opcode)
          OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
          OP_SHL, OP_SHR, OP_ADDI:         next_state = S_ARITH;
          OP_LDI:                          next_state = S_LDI;
          OP_LD, OP_ST, OP_STB:            next_state = S_MEM_ADDR;
          OP_MULS, OP_MULU, OP_MULSH,
          OP_MULUH:                        next_state = S_MUL;
          OP_NEG, OP_COM, OP_MOV:          next_state = S_UNARY;
          OP_BR:                           next_state = S_BRANCH;
          OP_JMP:                          next_state = S_JUMP;
          default:                         next_state = S_HALT;
        endcase
      end
      S_ARITH: begin
        ccr_write = 1'b1;
        case (opcode)
          OP_SUB:  alu_func = ALU_SUB;
          OP_AND:  alu_func = ALU_AND;
          OP_OR:   alu_func = ALU_OR;
          OP_XOR:  alu_func = ALU_XOR;
          OP_SHL:  alu_func = ALU_SHL;
          OP_SHR:  alu_func = ALU_SHR;
          default: alu_func = ALU_ADD;
        endcase
        if (opcode == OP_ADDI) begin
          alu2sel = ALU2_IMM;
        end
        next_state = S_ARITH_WB;
      end
      S_ARITH_WB: begin
        reg_write  = 1'b1;
        next_state = S_FETCH;
      end
      S_UNARY: begin
        reg_read_addr2 = rb;
        reg_write      = 1'b1;
        case (opcode)
          OP_NEG:  regsel = REG_NEG;
          OP_COM:  regsel = REG_COM;
          default: regsel = REG_MOV;
        endcase
        next_state = S_FETCH;
      end
      S_LDI: begin
        read = 1'b1;  // the constant sits at pc
        if (!waitrequest) begin
          mdrsel     = MDR_READ;
          pcsel      = PC_INC;
          next_state = S_LDI_WB;
        end
      end
      S_LDI_WB, S_LOAD_WB, S_MUL_WB: begin
        regsel     = REG_MDR;
        reg_write  = 1'b1;
        next_state = S_FETCH;
      end
      S_MEM_ADDR: begin
        alu2sel        = ALU2_IMM;
        marsel         = MAR_ALU;
        reg_read_addr2 = ra;  // store data
        mdrsel         = is_byte ? MDR_BYTE : MDR_REG;
        next_state     = (opcode == OP_LD) ? S_LOAD : S_STORE;
      end
      S_LOAD: begin
        read    = 1'b1;
        addrsel = 1'b1;
        if (!waitrequest) begin
          mdrsel     = MDR_READ;
          next_state = S_LOAD_WB;
        end
      end
      S_STORE: begin
        write      = 1'b1;
        addrsel    = 1'b1;
        byteenable = is_byte ? lane_be : 4'b1111;
        if (!waitrequest) begin
          next_state = S_FETCH;
        end
      end
      S_MUL: begin
        int_func   = mul_signed ? INT_MULS : INT_MULU;
        next_state = S_MUL_MDR;
      end
      S_MUL_MDR: begin
        mdrsel     = mul_high ? MDR_INTHI : MDR_INTLO;
        next_state = S_MUL_WB;
      end
      S_BRANCH: begin
        alu1sel    = ALU1_PC;  // pc already points past the branch
        alu2sel    = ALU2_BRA;
        next_state = S_BRANCH_PC;
      end
      S_BRANCH_PC: begin
        if (cond_true) begin
          pcsel = PC_ALUVAL;
        end
        next_state = S_FETCH;
      end
      S_JUMP: begin
        marsel     = MAR_REG;
        next_state = S_JUMP_PC;
      end
      S_JUMP_PC: begin
        pcsel      = PC_MAR;
        next_state = S_FETCH;
      end
      default: next_state = S_HALT;  // halt parks here with the bus idle
    endcase
  end

endmodule

// File: cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
  parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        waitrequest,
  input  logic [31:0] readdata,
  output logic [31:0] address,
  output logic        read,
  output logic        write,
  output logic [31:0] writedata,
  output logic [3:0]  byteenable
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  pcsel_e      pcsel;
  marsel_e     marsel;
  mdrsel_e     mdrsel;
  regsel_e     regsel;
  alu1sel_e    alu1sel;
  alu2sel_e    alu2sel;
  alu_func_e   alu_func;
  int_func_e   int_func;
  logic [4:0]  reg_read_addr1;
  logic [4:0]  reg_read_addr2;
  logic [4:0]  reg_write_addr;
  logic        reg_write;
  logic        ir_write;
  logic        ccr_write;
  logic        addrsel;

  instr_t      ir;
  logic [31:0] pc;
  logic [31:0] mar;
  logic [31:0] mdr;
  logic [31:0] aluval;
  logic [3:0]  ccr;
  logic [63:0] intval;  // registered inside intcalc

  logic [31:0] pc_next;
  logic [31:0] mar_next;
  logic [31:0] mdr_next;
  logic [31:0] reg_data_in;
  logic [31:0] reg_data1;
  logic [31:0] reg_data2;
  logic [31:0] alu_in1;
  logic [31:0] alu_in2;
  logic [31:0] alu_out;
  logic        alu_c;
  logic        alu_n;
  logic        alu_v;
  logic        alu_z;
  logic [31:0] imm_ext;
  logic [31:0] bra_ext;

  assign imm_ext   = {{21{ir.r.op.imm[10]}}, ir.r.op.imm};
  assign bra_ext   = {{14{ir.b.offset[15]}}, ir.b.offset, 2'b00};  // word offset to bytes
  assign address   = addrsel ? mar : pc;
  assign writedata = mdr;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc  <= RESET_VECTOR;
      ir  <= instr_t'(32'h0);
      ccr <= 4'h0;
    end else begin
      pc <= pc_next;
      if (ir_write) begin
        ir <= instr_t'(readdata);
      end
      if (ccr_write) begin
        ccr <= {alu_c, alu_n, alu_v, alu_z};
      end
    end
  end

  always_ff @(posedge clk) begin
    mar    <= mar_next;
    mdr    <= mdr_next;
    aluval <= alu_out;
  end

  always_comb begin
    case (pcsel)
      PC_INC:    pc_next = pc + 32'd4;
      PC_MAR:    pc_next = mar;
      PC_ALUVAL: pc_next = aluval;
      default:   pc_next = pc;
    endcase
    case (marsel)
      MAR_ALU: mar_next = alu_out;
      MAR_REG: mar_next = reg_data1;
      default: mar_next = mar;
    endcase
    case (mdrsel)
      MDR_READ:  mdr_next = readdata;
      MDR_REG:   mdr_next = reg_data2;
      MDR_BYTE:  mdr_next = {4{reg_data2[7:0]}};
      MDR_INTLO: mdr_next = intval[31:0];
      MDR_INTHI: mdr_next = intval[63:32];
      default:   mdr_next = mdr;
    endcase
    case (regsel)
      REG_MDR: reg_data_in = mdr;
      REG_NEG: reg_data_in = -reg_data2;
      REG_COM: reg_data_in = ~reg_data2;
      REG_MOV: reg_data_in = reg_data2;
      default: reg_data_in = aluval;
    endcase
    alu_in1 = (alu1sel == ALU1_PC) ? pc : reg_data1;
    case (alu2sel)
      ALU2_IMM: alu_in2 = imm_ext;
      ALU2_BRA: alu_in2 = bra_ext;
      default:  alu_in2 = reg_data2;
    endcase
  end

  control u_control (
    .clk(clk), .reset_n(reset_n), .ir(ir), .ccr(ccr), .mar_low(mar[1:0]),
    .waitrequest(waitrequest),
    .pcsel(pcsel), .marsel(marsel), .mdrsel(mdrsel), .regsel(regsel),
    .alu1sel(alu1sel), .alu2sel(alu2sel), .int2sel(),
    .reg_read_addr1(reg_read_addr1), .reg_read_addr2(reg_read_addr2),
    .reg_write_addr(reg_write_addr), .reg_write(reg_write),
    .ir_write(ir_write), .ccr_write(ccr_write),
    .alu_func(alu_func), .int_func(int_func), .addrsel(addrsel),
    .read(read), .write(write), .byteenable(byteenable)
  );

  alu u_alu (
    .in1(alu_in1), .in2(alu_in2), .func(alu_func), .out(alu_out),
    .c_out(alu_c), .n_out(alu_n), .v_out(alu_v), .z_out(alu_z)
  );

  intcalc u_intcalc (
    .clk(clk), .func(int_func), .in1(reg_data1), .in2(reg_data2), .out(intval)
  );

  registerfile u_registerfile (
    .clk(clk), .reset_n(reset_n), .read1(reg_read_addr1), .read2(reg_read_addr2),
    .write_addr(reg_write_addr), .write_data(reg_data_in), .write_en(reg_write),
    .data1(reg_data1), .data2(reg_data2)
  );

endmodule

// File: tb_memory.sv
`timescale 1ns/1ps

module tb_memory #(
  parameter logic [31:0] RESET_VECTOR = 32'h0000_0100,
  parameter logic [31:0] RESULT_BASE  = 32'h0000_0800,
  parameter int          BYTE_OFFSET  = 256,
  parameter logic [31:0] END_ADDR     = 32'hFFFF_FFF0,
  parameter logic [31:0] OPND_A       = 32'h0,
  parameter logic [31:0] OPND_B       = 32'h0,
  parameter logic [31:0] MUL_X        = 32'h0,
  parameter logic [31:0] MUL_Y        = 32'h0,
  parameter int          SHAMT        = 0,
  parameter int          IMM_NEG      = 0,
  parameter logic [31:0] MARK_TAKEN   = 32'h0,
  parameter logic [31:0] MARK_SKIP    = 32'h0
) (
  input  logic        clk,
  input  logic [31:0] address,
  input  logic        write,
  input  logic [31:0] writedata,
  input  logic [3:0]  byteenable,
  output logic [31:0] readdata,
  output logic        waitrequest,
  output logic [31:0] jump_addr,
  output logic [31:0] jump_target
);
  import isa_pkg::*;

  localparam logic [4:0] R0 = 5'd0;
  localparam logic [4:0] R_A = 5'd1;
  localparam logic [4:0] R_B = 5'd2;
  localparam logic [4:0] R_SH = 5'd3;
  localparam logic [4:0] R_X = 5'd4;
  localparam logic [4:0] R_Y = 5'd5;
  localparam logic [4:0] R_MT = 5'd6;
  localparam logic [4:0] R_MS = 5'd7;
  localparam logic [4:0] R_T = 5'd8;
  localparam logic [4:0] R_F = 5'd9;   // flag scratch
  localparam logic [4:0] R_BY = 5'd10;
  localparam logic [4:0] R_J = 5'd11;
  localparam logic [4:0] R_W = 5'd12;
  localparam logic [4:0] R_END = 5'd13;
  localparam logic [4:0] R_BASE = 5'd30;

  logic [31:0] mem [1024];  // word index is address[11:2]
  logic [31:0] emit_addr;
  integer      seed;

  assign readdata = mem[address[11:2]];

  function automatic logic [31:0] asm_reg(opcode_e op, logic [4:0] ra, logic [4:0] rb,
                                          logic [4:0] rc);
    instr_t w;
    w = '0;
    w.r.opcode = op;
    w.r.ra = ra;
    w.r.rb = rb;
    w.r.op.regs.rc = rc;
    return w;
  endfunction

  function automatic logic [31:0] asm_imm(opcode_e op, logic [4:0] ra, logic [4:0] rb,
                                          logic [10:0] imm);
    instr_t w;
    w = '0;
    w.r.opcode = op;
    w.r.ra = ra;
    w.r.rb = rb;
    w.r.op.imm = imm;
    return w;
  endfunction

  function automatic logic [31:0] asm_branch(cond_e c, logic [15:0] offset);
    instr_t w;
    w = '0;
    w.b.opcode = OP_BR;
    w.b.cond = c;
    w.b.offset = offset;
    return w;
  endfunction

  task automatic emit(logic [31:0] word);
    mem[emit_addr[11:2]] = word;
    emit_addr = emit_addr + 32'd4;
  endtask

  task automatic emit_ldi(logic [4:0] rd, logic [31:0] value);
    emit(asm_imm(OP_LDI, rd, R0, 11'd0));
    emit(value);
  endtask

  task automatic emit_store(logic [4:0] rs, int slot);
    emit(asm_imm(OP_ST, rs, R_BASE, 11'(4 * slot)));
  endtask

  // compare, then store the marker of whichever path runs
  task automatic emit_branch_test(cond_e c, logic [4:0] rx, logic [4:0] ry, int slot);
    emit(asm_reg(OP_SUB, R_F, rx, ry));
    emit(asm_branch(c, 16'd2));
    emit_store(R_MS, slot);
    emit(asm_branch(COND_AL, 16'd1));
    emit_store(R_MT, slot);
  endtask

  initial begin
    seed = 34;
    waitrequest = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'hA5C3_0000 ^ (i * 32'h0001_0004);
    end
    emit_addr = RESET_VECTOR;
    emit_ldi(R_A, OPND_A);
    emit_ldi(R_B, OPND_B);
    emit_ldi(R_X, MUL_X);
    emit_ldi(R_Y, MUL_Y);
    emit_ldi(R_MT, MARK_TAKEN);
    emit_ldi(R_MS, MARK_SKIP);
    emit_ldi(R_BASE, RESULT_BASE);
    emit(asm_imm(OP_ADDI, R_SH, R0, 11'(SHAMT)));
    emit(asm_reg(OP_ADD, R_T, R_A, R_B));
    emit_store(R_T, 0);
    emit(asm_reg(OP_SUB, R_T, R_A, R_B));
    emit_store(R_T, 1);
    emit(asm_reg(OP_AND, R_T, R_A, R_B));
    emit_store(R_T, 2);
    emit(asm_reg(OP_OR, R_T, R_A, R_B));
    emit_store(R_T, 3);
    emit(asm_reg(OP_XOR, R_T, R_A, R_B));
    emit_store(R_T, 4);
    emit(asm_reg(OP_SHL, R_T, R_A, R_SH));
    emit_store(R_T, 5);
    emit(asm_reg(OP_SHR, R_T, R_A, R_SH));
    emit_store(R_T, 6);
    emit(asm_imm(OP_ADDI, R_T, R_A, 11'(IMM_NEG)));
    emit_store(R_T, 7);
    emit(asm_reg(OP_NEG, R_T, R_A, R0));
    emit_store(R_T, 8);
    emit(asm_reg(OP_COM, R_T, R_A, R0));
    emit_store(R_T, 9);
    emit(asm_reg(OP_MOV, R_T, R_B, R0));
    emit_store(R_T, 10);
    emit(asm_reg(OP_MULS, R_T, R_X, R_Y));
    emit_store(R_T, 11);
    emit(asm_reg(OP_MULSH, R_T, R_X, R_Y));
    emit_store(R_T, 12);
    emit(asm_reg(OP_MULU, R_T, R_X, R_Y));
    emit_store(R_T, 13);
    emit(asm_reg(OP_MULUH, R_T, R_X, R_Y));
    emit_store(R_T, 14);
    emit_branch_test(COND_EQ, R_A, R_A, 15);
    emit_branch_test(COND_EQ, R_A, R_B, 16);
    emit_branch_test(COND_NE, R_A, R_B, 17);
    emit_branch_test(COND_NE, R_A, R_A, 18);
    emit_branch_test(COND_LT, R_B, R_A, 19);
    emit_branch_test(COND_LT, R_A, R_B, 20);
    emit_branch_test(COND_CS, R_B, R_A, 21);
    emit_branch_test(COND_CS, R_A, R_B, 22);
    for (int k = 0; k < 4; k++) begin
      emit(asm_imm(OP_ADDI, R_BY, R0, 11'(17 * (k + 1))));  // 0x11, 0x22, 0x33, 0x44
      emit(asm_imm(OP_STB, R_BY, R_BASE, 11'(BYTE_OFFSET + k)));
    end
    emit(asm_imm(OP_LD, R_W, R_BASE, 11'(BYTE_OFFSET)));
    emit_store(R_W, 23);
    // jump over two halts
    jump_addr = emit_addr + 32'd8;
    jump_target = emit_addr + 32'd20;
    emit_ldi(R_J, jump_target);
    emit(asm_reg(OP_JMP, R0, R_J, R0));
    emit(asm_reg(OP_HALT, R0, R0, R0));
    emit(asm_reg(OP_HALT, R0, R0, R0));
    emit_ldi(R_END, END_ADDR);
    emit(asm_imm(OP_ST, R0, R_END, 11'd0));
    emit(asm_reg(OP_HALT, R0, R0, R0));
  end

  always @(posedge clk) begin
    waitrequest <= (($random(seed) % 3) == 0);  // about one cycle in three busy
    if (write && !waitrequest) begin
      for (int b = 0; b < 4; b++) begin
        if (byteenable[b]) begin
          mem[address[11:2]][8*b +: 8] <= writedata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

  localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;
  localparam logic [31:0] RESULT_BASE = 32'h0000_0800;
  localparam int BYTE_OFFSET = 256;
  localparam logic [31:0] BYTE_ADDR = RESULT_BASE + 32'(BYTE_OFFSET);
  localparam logic [31:0] END_ADDR = 32'hFFFF_FFF0;
  localparam logic [31:0] OPND_A = 32'h1234_5678;
  localparam logic [31:0] OPND_B = 32'h0F0F_00FF;
  localparam logic [31:0] MUL_X = 32'hFFFF_FFF3;  // -13
  localparam logic [31:0] MUL_Y = 32'h0001_2345;
  localparam int SHAMT = 5;
  localparam int IMM_NEG = -100;
  localparam logic [31:0] MARK_TAKEN = 32'h7A4E_0001;
  localparam logic [31:0] MARK_SKIP = 32'h5C1F_0002;
  localparam int NUM_SLOTS = 24;
  localparam int EXPECTED_STORES = NUM_SLOTS + 4 + 1;  // results, byte stores, final store
  localparam int TIMEOUT_NS = 50 * 8 * 4 * 40;

  logic        clk;
  logic        reset_n;
  logic        waitrequest;
  logic [31:0] readdata;
  logic [31:0] address;
  logic        read;
  logic        write;
  logic [31:0] writedata;
  logic [3:0]  byteenable;
  logic [31:0] jump_addr;
  logic [31:0] jump_target;
  logic        first_read_seen = 1'b0;
  logic        jump_pending = 1'b0;
  logic        done = 1'b0;
  int          stores_done = 0;
  int          byte_stores = 0;

  cpu_core #(.RESET_VECTOR(RESET_VECTOR)) DUT (
    .clk(clk), .reset_n(reset_n), .waitrequest(waitrequest), .readdata(readdata),
    .address(address), .read(read), .write(write), .writedata(writedata),
    .byteenable(byteenable)
  );

  tb_memory #(
    .RESET_VECTOR(RESET_VECTOR), .RESULT_BASE(RESULT_BASE), .BYTE_OFFSET(BYTE_OFFSET),
    .END_ADDR(END_ADDR), .OPND_A(OPND_A), .OPND_B(OPND_B), .MUL_X(MUL_X), .MUL_Y(MUL_Y),
    .SHAMT(SHAMT), .IMM_NEG(IMM_NEG), .MARK_TAKEN(MARK_TAKEN), .MARK_SKIP(MARK_SKIP)
  ) mem_model (
    .clk(clk), .address(address), .write(write), .writedata(writedata),
    .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest),
    .jump_addr(jump_addr), .jump_target(jump_target)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  // same operand pairs as the branch tests in the program
  // tests come in pairs per condition: eq, ne, lt, carry
  function automatic logic branch_taken(int j);
    logic [31:0] x;
    logic [31:0] y;
    case (j)
      0, 3: begin
        x = OPND_A;
        y = OPND_A;
      end
      4, 6: begin
        x = OPND_B;
        y = OPND_A;
      end
      default: begin
        x = OPND_A;
        y = OPND_B;
      end
    endcase
    case (j / 2)
      0: return x == y;
      1: return x != y;
      2: return $signed(x) < $signed(y);
      default: return x < y;  // carry set means unsigned borrow
    endcase
  endfunction

  function automatic logic [31:0] expected_word(logic [31:0] addr);
    logic [31:0] slot;
    longint      prod_s;
    logic [63:0] prod_u;
    slot = (addr - RESULT_BASE) >> 2;
    prod_s = longint'($signed(MUL_X)) * longint'($signed(MUL_Y));
    prod_u = 64'(MUL_X) * 64'(MUL_Y);
    case (slot)
      0: return OPND_A + OPND_B;
      1: return OPND_A - OPND_B;
      2: return OPND_A & OPND_B;
      3: return OPND_A | OPND_B;
      4: return OPND_A ^ OPND_B;
      5: return OPND_A << SHAMT;
      6: return OPND_A >> SHAMT;
      7: return OPND_A + 32'(IMM_NEG);
      8: return 32'h0 - OPND_A;
      9: return ~OPND_A;
      10: return OPND_B;
      11: return prod_s[31:0];
      12: return prod_s[63:32];
      13: return prod_u[31:0];
      14: return prod_u[63:32];
      23: return 32'h4433_2211;  // four byte stores merged
      default: return branch_taken(int'(slot) - 15) ? MARK_TAKEN : MARK_SKIP;
    endcase
  endfunction

  // the k-th byte store of the program goes to lane k
  function automatic logic [7:0] lane_byte(int k);
    case (k)
      0: return 8'h11;
      1: return 8'h22;
      2: return 8'h33;
      default: return 8'h44;
    endcase
  endfunction

  function automatic logic [3:0] lane_enable(int k);
    case (k)
      0: return 4'b0001;
      1: return 4'b0010;
      2: return 4'b0100;
      default: return 4'b1000;
    endcase
  endfunction

  always @(posedge clk) begin
    if (reset_n && read) begin
      first_read_seen <= 1'b1;
    end
    if (read && !waitrequest) begin
      jump_pending <= (address == jump_addr);
    end
    if (reset_n && write && !waitrequest) begin
      stores_done <= stores_done + 1;
      if (byteenable != 4'hF) begin
        byte_stores <= byte_stores + 1;
      end
      if (address == END_ADDR) begin
        done <= 1'b1;
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk) !reset_n |-> (!read && !write))
    else fail_run("Error: bus strobe active during reset");

  a_reset_exit: assert property (@(posedge clk) $rose(reset_n) |-> (!read && !write))
    else fail_run("Error: bus strobe active in the first cycle after reset");

  a_first_fetch: assert property (@(posedge clk)
      (reset_n && read && !first_read_seen) |-> address == RESET_VECTOR)
    else fail_run($sformatf("Error: address 0x%h on first fetch, expected 0x%h",
                            $sampled(address), RESET_VECTOR));

  a_strobe_excl: assert property (@(posedge clk) !(read && write))
    else fail_run("Error: read and write are high together");

  a_hold_on_wait: assert property (@(posedge clk) disable iff (!reset_n)
      ($past(read || write) && $past(waitrequest)) |->
      ($stable(address) && $stable(read) && $stable(write) && $stable(writedata) &&
       $stable(byteenable)))
    else fail_run("Error: bus outputs changed while waitrequest was high");

  a_store_addr: assert property (@(posedge clk) disable iff (!reset_n)
      (write && !waitrequest && byteenable == 4'hF) |->
      (address == END_ADDR || (address >= RESULT_BASE && address[1:0] == 2'b00 &&
       address < RESULT_BASE + 32'(4 * NUM_SLOTS))))
    else fail_run($sformatf("Error: word store to unexpected address 0x%h",
                            $sampled(address)));

  a_store_value: assert property (@(posedge clk) disable iff (!reset_n)
      (write && !waitrequest && byteenable == 4'hF && address != END_ADDR) |->
      writedata == expected_word(address))
    else fail_run($sformatf("Error: writedata 0x%h at 0x%h, expected 0x%h",
                            $sampled(writedata), $sampled(address),
                            expected_word($sampled(address))));

  a_byte_lane: assert property (@(posedge clk) disable iff (!reset_n)
      (write && byteenable != 4'hF) |->
      (address == BYTE_ADDR + 32'(byte_stores) && byteenable == lane_enable(byte_stores)))
    else fail_run($sformatf("Error: byteenable 0x%h at address 0x%h, expected 0x%h at 0x%h",
                            $sampled(byteenable), $sampled(address),
                            lane_enable($sampled(byte_stores)),
                            BYTE_ADDR + 32'($sampled(byte_stores))));

  a_byte_value: assert property (@(posedge clk) disable iff (!reset_n)
      (write && byteenable != 4'hF) |->
      writedata[8*byte_stores +: 8] == lane_byte(byte_stores))
    else fail_run($sformatf("Error: writedata 0x%h, expected byte 0x%h in lane %0d",
                            $sampled(writedata), lane_byte($sampled(byte_stores)),
                            $sampled(byte_stores)));

  // the fetch after the jump must come from its target
  a_jump_target: assert property (@(posedge clk) disable iff (!reset_n)
      (read && !waitrequest && jump_pending) |-> address == jump_target)
    else fail_run($sformatf("Error: address 0x%h after jump, expected 0x%h",
                            $sampled(address), jump_target));

  initial begin
    reset_n = 1'b0;
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    wait (done);
    @(posedge clk);
    if (stores_done == EXPECTED_STORES) begin
      $display("No errors");
      $finish;
    end else begin
      fail_run($sformatf("Error: %0d stores seen, expected %0d", stores_done,
                         EXPECTED_STORES));
    end
  end

  initial begin
    #(TIMEOUT_NS);
    fail_run("Timeout: the program did not reach its final store");
  end

endmodule

// File: build.f
isa_pkg.sv
ctrl_pkg.sv
alu.sv
intcalc.sv
registerfile.sv
control.sv
cpu_core.sv
tb_memory.sv
tb_cpu_core.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide on the log contents
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_cpu_core &&
  ./obj_dir/Vtb_cpu_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
